// File: bench/search_assertions.sv
`timescale 1ns/1ps

module search_assertions (
    input logic clk_in,
    input logic rst_in,
    input logic go_in,
    input logic ready_out,
    input logic valid_out
);

    // result strobe is a single cycle
    valid_single_cycle: assert property (@(posedge clk_in) disable iff (rst_in)
        valid_out |=> !valid_out)
        else $error("valid_out stayed high for two cycles");

    ready_valid_exclusive: assert property (@(posedge clk_in) disable iff (rst_in)
        !(ready_out && valid_out))
        else $error("ready_out and valid_out high together");

    // an accepted go leaves the idle level
    ready_drops_on_go: assert property (@(posedge clk_in) disable iff (rst_in)
        (ready_out && go_in) |=> !ready_out)
        else $error("ready_out did not fall after an accepted go_in");

endmodule

// File: bench/search_tb.sv
`timescale 1ns/1ps

module search_tb;
    import search_pkg::*;

    localparam int MAX_DEPTH = 16;
    localparam int DEPTH_W = $clog2(MAX_DEPTH);
    localparam int WAIT_LIMIT = 200000;
    localparam logic [31:0] AMPLE_TIME = 32'h00ff_ffff;
    // game constants of the synthetic rules
    localparam logic [15:0] MIX = 16'h2f1b;
    localparam eval_t START_SCORE = -16'sd32760;

    logic               clk_in;
    logic               rst_in;
    position_t          board_in;
    logic               board_valid_in;
    logic               go_in;
    logic [31:0]        time_in;
    logic [DEPTH_W-1:0] depth_in;
    logic               ready_out;
    move_t              bestmove_out;
    eval_t              score_out;
    logic               valid_out;

    logic [31:0] lcg_state;
    move_t       expected_moves[$];
    eval_t       expected_scores[$];
    int          results_seen;

    search_engine_top #(
        .MAX_DEPTH(MAX_DEPTH)
    ) DUT (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .board_in(board_in),
        .board_valid_in(board_valid_in),
        .go_in(go_in),
        .time_in(time_in),
        .depth_in(depth_in),
        .ready_out(ready_out),
        .bestmove_out(bestmove_out),
        .score_out(score_out),
        .valid_out(valid_out)
    );

    bind search_engine_top search_assertions assertions (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .go_in(go_in),
        .ready_out(ready_out),
        .valid_out(valid_out)
    );

    always begin
        #5 clk_in = ~clk_in;
    end

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic position_t next_root();
        position_t p;
        lcg_state = lcg_next(lcg_state);
        p.key = lcg_state[31:16];
        p.side = lcg_state[15];
        return p;
    endfunction

    function automatic int move_count(logic [15:0] key);
        return 2 + int'(key[1:0]);
    endfunction

    function automatic logic [15:0] child_key(logic [15:0] key, int m);
        logic [15:0] rot;
        rot = {key[10:0], key[15:11]};
        return rot + MIX * 16'(m + 1);
    endfunction

    // low 11 key bits as a signed number
    function automatic int static_eval(logic [15:0] key);
        int v;
        v = int'(key[10:0]);
        if (key[10]) begin
            v = v - 2048;
        end
        return v;
    endfunction

    function automatic int negamax(logic [15:0] key, int depth);
        int best;
        int value;
        if (depth == 0) begin
            return static_eval(key);
        end
        best = -100000;
        for (int m = 0; m < move_count(key); m++) begin
            value = -negamax(child_key(key, m), depth - 1);
            if (value > best) begin
                best = value;
            end
        end
        return best;
    endfunction

    // first move that reaches the maximum wins
    function automatic void reference_search(input logic [15:0] key, input int depth,
                                             output move_t move, output eval_t score);
        int best;
        int value;
        best = -100000;
        move = '0;
        for (int m = 0; m < move_count(key); m++) begin
            value = -negamax(child_key(key, m), depth - 1);
            if (value > best) begin
                best = value;
                move = move_t'(m);
            end
        end
        score = eval_t'(best);
    endfunction

    task automatic stop_run(string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_move(move_t got, move_t expected, string what);
        if (got !== expected) begin
            stop_run($sformatf("[FAIL] %0t: %s bestmove got %0d expected %0d",
                               $time, what, got, expected));
        end
    endtask

    task automatic check_score(eval_t got, eval_t expected, string what);
        if (got !== expected) begin
            stop_run($sformatf("[FAIL] %0t: %s score got %0d expected %0d",
                               $time, what, got, expected));
        end
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (ready_out !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(posedge clk_in);
            #1;
            cycles++;
        end
        if (ready_out !== 1'b1) begin
            stop_run("timeout: the engine never became ready");
        end
    endtask

    task automatic wait_result();
        int cycles;
        cycles = 0;
        while (valid_out !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(posedge clk_in);
            #1;
            cycles++;
        end
        if (valid_out !== 1'b1) begin
            stop_run("timeout: the search never produced a result");
        end else begin
            @(posedge clk_in);
            #1;
            if (ready_out !== 1'b1) begin
                stop_run("ready_out did not return the cycle after valid_out");
            end
        end
    endtask

    task automatic load_board(position_t root);
        wait_ready();
        board_in = root;
        board_valid_in = 1'b1;
        @(posedge clk_in);
        #1;
        board_valid_in = 1'b0;
    endtask

    task automatic start_search(int depth, logic [31:0] time_left, move_t exp_move,
                                eval_t exp_score);
        expected_moves.push_back(exp_move);
        expected_scores.push_back(exp_score);
        wait_ready();
        depth_in = DEPTH_W'(depth);
        time_in = time_left;
        go_in = 1'b1;
        @(posedge clk_in);
        #1;
        go_in = 1'b0;
        wait_result();
    endtask

    task automatic search_and_check(position_t root, int depth, logic [31:0] time_left);
        move_t exp_move;
        eval_t exp_score;
        reference_search(root.key, depth, exp_move, exp_score);
        load_board(root);
        start_search(depth, time_left, exp_move, exp_score);
    endtask

    // compares every result strobe against the oldest pending expectation
    initial begin
        forever begin
            @(posedge clk_in);
            #2;
            if (valid_out === 1'b1) begin
                if (expected_moves.size() == 0) begin
                    stop_run("valid_out pulsed while no search was pending");
                end else begin
                    check_move(bestmove_out, expected_moves.pop_front(),
                               $sformatf("search %0d", results_seen));
                    check_score(score_out, expected_scores.pop_front(),
                                $sformatf("search %0d", results_seen));
                    results_seen++;
                end
            end
        end
    end

    initial begin
        position_t root;
        move_t     exp_move;
        eval_t     exp_score;
        clk_in = 1'b0;
        rst_in = 1'b1;
        board_in = '0;
        board_valid_in = 1'b0;
        go_in = 1'b0;
        time_in = AMPLE_TIME;
        depth_in = DEPTH_W'(1);
        lcg_state = 32'h3fec;
        results_seen = 0;
        repeat (3) @(posedge clk_in);
        #1;
        rst_in = 1'b0;

        if (ready_out !== 1'b1 || valid_out !== 1'b0) begin
            stop_run("after reset ready_out was not high or valid_out was not low");
        end

        repeat (5) search_and_check(next_root(), 1, AMPLE_TIME);

        for (int d = 2; d <= 5; d++) begin
            repeat (3) search_and_check(next_root(), d, AMPLE_TIME + 32'(d));
        end

        // one load followed by two searches
        root = next_root();
        reference_search(root.key, 4, exp_move, exp_score);
        load_board(root);
        start_search(4, AMPLE_TIME, exp_move, exp_score);
        start_search(4, AMPLE_TIME, exp_move, exp_score);

        // zero time aborts before any iteration completes
        load_board(next_root());
        start_search(5, 32'd0, '0, START_SCORE);
        search_and_check(next_root(), 5, AMPLE_TIME);
        search_and_check(next_root(), 3, 32'd1);

        $display("Testbench passed");
        $finish;
    end

endmodule

// File: design/move_generator.sv
`timescale 1ns/1ps

module move_generator (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  search_pkg::position_t gen_position,
    input  search_pkg::move_t     gen_move,
    input  logic                  gen_valid,
    output search_pkg::position_t child_position,
    output search_pkg::move_t     parent_num_moves,
    output logic                  child_valid
);
    import search_pkg::*;

    logic [KEY_W-1:0] rotated_key;
    logic [KEY_W-1:0] move_weight;
    logic [KEY_W-1:0] mix_term;
    move_t            move_count;

    assign rotated_key = {gen_position.key[KEY_W-ROT_AMOUNT-1:0],
                          gen_position.key[KEY_W-1:KEY_W-ROT_AMOUNT]};

    // moves are numbered from 0 so the mix uses m + 1
    assign move_weight = KEY_W'(gen_move) + KEY_W'(1);
    assign mix_term = MIX_CONSTANT * move_weight;

    assign move_count = move_t'(BASE_MOVES) + move_t'(gen_position.key[1:0]);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            child_valid <= 1'b0;
        end else begin
            child_valid <= gen_valid;
        end
    end

    // outputs hold until the next request
    always_ff @(posedge clk_in) begin
        if (gen_valid) begin
            child_position.key <= rotated_key + mix_term;
            child_position.side <= ~gen_position.side;
            parent_num_moves <= move_count;
        end
    end

endmodule

// File: design/position_evaluator.sv
`timescale 1ns/1ps

module position_evaluator (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  search_pkg::position_t eval_position,
    input  logic                  eval_valid,
    output search_pkg::eval_t     eval_score,
    output logic                  eval_done
);
    import search_pkg::*;

    logic [EVAL_KEY_W-1:0] low_key;
    eval_t                 stage1_score;
    logic                  stage1_valid;

    // score is seen from the side to move
    assign low_key = eval_position.key[EVAL_KEY_W-1:0];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            stage1_valid <= 1'b0;
            eval_done <= 1'b0;
        end else begin
            stage1_valid <= eval_valid;
            eval_done <= stage1_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        stage1_score <= {{(EVAL_W-EVAL_KEY_W){low_key[EVAL_KEY_W-1]}}, low_key};
        eval_score <= stage1_score;
    end

endmodule

// File: design/search_coordinator.sv
`timescale 1ns/1ps

module search_coordinator #(
    parameter int MAX_DEPTH = 16
) (
    input  logic                         clk_in,
    input  logic                         rst_in,
    input  search_pkg::position_t        board_in,
    input  logic                         board_valid_in,
    input  logic                         go_in,
    input  logic [31:0]                  time_in,
    input  logic [$clog2(MAX_DEPTH)-1:0] depth_in,
    input  search_pkg::frame_t           cur_frame,
    input  search_pkg::frame_t           parent_frame,
    input  search_pkg::position_t        child_position,
    input  search_pkg::move_t            parent_num_moves,
    input  logic                         child_valid,
    input  search_pkg::eval_t            eval_score,
    input  logic                         eval_done,
    output search_pkg::position_t        gen_position,
    output search_pkg::move_t            gen_move,
    output logic                         gen_valid,
    output search_pkg::position_t        eval_position,
    output logic                         eval_valid,
    output logic                         wr_en,
    output logic [$clog2(MAX_DEPTH)-1:0] wr_depth,
    output search_pkg::frame_t           wr_frame,
    output logic [$clog2(MAX_DEPTH)-1:0] cur_depth,
    output logic                         ready_out,
    output search_pkg::move_t            bestmove_out,
    output search_pkg::eval_t            score_out,
    output logic                         valid_out
);
    import search_pkg::*;

    localparam int DEPTH_W = $clog2(MAX_DEPTH);

    search_state_e      state;
    logic [DEPTH_W-1:0] target_depth;
    position_t          root_position;
    logic               eval_busy;
    logic               wb_push;
    move_t              iter_best_move;
    move_t              last_move;
    eval_t              last_score;

    logic               abort;
    logic               go_accept;
    logic               at_target;
    logic               leaf_done;
    logic               root_done;
    logic               deepen;
    eval_t              child_score;
    eval_t              backed_score;
    eval_t              backed_alpha;
    move_t              next_idx;
    logic               pop;

    function automatic frame_t fresh_frame(position_t pos, eval_t alpha, eval_t beta);
        frame_t f;
        f.position = pos;
        f.alpha = alpha;
        f.beta = beta;
        f.score = SCORE_MIN;
        f.move_idx = '0;
        f.num_moves = '0;
        return f;
    endfunction

    assign abort = (state != SEARCH_READY) && (time_in == 32'd0);
    assign go_accept = (state == SEARCH_READY) && ready_out && go_in;
    assign at_target = (cur_depth == target_depth);
    assign leaf_done = (state == SEARCH_NEXT) && at_target && eval_busy && eval_done;
    assign root_done = (state == SEARCH_FINISH) && (cur_depth == '0) && !abort;
    assign deepen = (target_depth < depth_in);

    // negamax backup of a finished node into its parent
    assign child_score = -cur_frame.score;
    assign backed_score = (child_score > parent_frame.score) ? child_score : parent_frame.score;
    assign backed_alpha = (child_score > parent_frame.alpha) ? child_score : parent_frame.alpha;
    assign next_idx = parent_frame.move_idx + move_t'(1);
    assign pop = (child_score > parent_frame.beta) || (next_idx >= parent_frame.num_moves);

    // a stack write shows on the reads one cycle later
    always_comb begin
        wr_en = 1'b0;
        wr_depth = cur_depth;
        wr_frame = cur_frame;
        case (state)
            SEARCH_READY: begin
                if (go_accept) begin
                    wr_en = 1'b1;
                    wr_depth = '0;
                    wr_frame = fresh_frame(root_position, -EVAL_INF, EVAL_INF);
                end
            end
            SEARCH_NEXT: begin
                if (leaf_done) begin
                    wr_en = 1'b1;
                    wr_frame.score = eval_score;
                end
            end
            SEARCH_WRITEBACK: begin
                wr_en = 1'b1;
                if (wb_push) begin
                    // child window is the parent's window negated and swapped
                    wr_depth = cur_depth + 1'b1;
                    wr_frame = fresh_frame(child_position, -cur_frame.beta, -cur_frame.alpha);
                end else begin
                    wr_frame.num_moves = parent_num_moves;
                end
            end
            SEARCH_FINISH: begin
                if (cur_depth == '0) begin
                    wr_en = deepen;
                    wr_frame = fresh_frame(root_position, -EVAL_INF, EVAL_INF);
                end else begin
                    wr_en = 1'b1;
                    wr_depth = cur_depth - 1'b1;
                    wr_frame = parent_frame;
                    wr_frame.score = backed_score;
                    wr_frame.alpha = backed_alpha;
                    wr_frame.move_idx = next_idx;
                end
            end
            default: begin
                wr_en = 1'b0;
            end
        endcase
        if (abort) begin
            wr_en = 1'b0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= SEARCH_READY;
            ready_out <= 1'b1;
            valid_out <= 1'b0;
            cur_depth <= '0;
            target_depth <= '0;
            eval_busy <= 1'b0;
            wb_push <= 1'b0;
            gen_valid <= 1'b0;
            eval_valid <= 1'b0;
        end else if (abort) begin
            state <= SEARCH_READY;
            valid_out <= 1'b1;
            eval_busy <= 1'b0;
            wb_push <= 1'b0;
            gen_valid <= 1'b0;
            eval_valid <= 1'b0;
        end else begin
            gen_valid <= 1'b0;
            eval_valid <= 1'b0;
            case (state)
                SEARCH_READY: begin
                    valid_out <= 1'b0;
                    if (go_accept) begin
                        ready_out <= 1'b0;
                        cur_depth <= '0;
                        target_depth <= DEPTH_W'(1);
                        state <= SEARCH_NEXT;
                    end else begin
                        ready_out <= 1'b1;
                    end
                end
                SEARCH_NEXT: begin
                    if (at_target) begin
                        if (!eval_busy) begin
                            eval_valid <= 1'b1;
                            eval_busy <= 1'b1;
                        end else if (eval_done) begin
                            eval_busy <= 1'b0;
                            state <= SEARCH_FINISH;
                        end
                    end else begin
                        gen_valid <= 1'b1;
                        state <= SEARCH_GENERATING;
                    end
                end
                SEARCH_GENERATING: begin
                    if (child_valid) begin
                        state <= SEARCH_WRITEBACK;
                    end
                end
                SEARCH_WRITEBACK: begin
                    // the first cycle records the move count and the second pushes the child
                    wb_push <= !wb_push;
                    if (wb_push) begin
                        cur_depth <= cur_depth + 1'b1;
                        state <= SEARCH_NEXT;
                    end
                end
                SEARCH_FINISH: begin
                    if (cur_depth == '0) begin
                        if (deepen) begin
                            target_depth <= target_depth + 1'b1;
                            state <= SEARCH_NEXT;
                        end else begin
                            valid_out <= 1'b1;
                            state <= SEARCH_READY;
                        end
                    end else begin
                        cur_depth <= cur_depth - 1'b1;
                        state <= pop ? SEARCH_FINISH : SEARCH_NEXT;
                    end
                end
                default: begin
                    state <= SEARCH_READY;
                end
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (state == SEARCH_READY && board_valid_in) begin
            root_position <= board_in;
        end
        if (state == SEARCH_NEXT && !at_target) begin
            gen_position <= cur_frame.position;
            gen_move <= cur_frame.move_idx;
        end
        if (state == SEARCH_NEXT && at_target && !eval_busy) begin
            eval_position <= cur_frame.position;
        end
        // only a strictly better root child takes over
        if (state == SEARCH_FINISH && cur_depth == DEPTH_W'(1)
                && child_score > parent_frame.score) begin
            iter_best_move <= parent_frame.move_idx;
        end
        if (go_accept) begin
            last_move <= '0;
            last_score <= SCORE_MIN;
        end else if (root_done) begin
            last_move <= iter_best_move;
            last_score <= cur_frame.score;
        end
        if (abort) begin
            bestmove_out <= last_move;
            score_out <= last_score;
        end else if (root_done && !deepen) begin
            bestmove_out <= iter_best_move;
            score_out <= cur_frame.score;
        end
    end

endmodule

// File: design/search_engine_top.sv
`timescale 1ns/1ps

module search_engine_top #(
    parameter int MAX_DEPTH = 16
) (
    input  logic                         clk_in,
    input  logic                         rst_in,
    input  search_pkg::position_t        board_in,
    input  logic                         board_valid_in,
    input  logic                         go_in,
    input  logic [31:0]                  time_in,
    input  logic [$clog2(MAX_DEPTH)-1:0] depth_in,
    output logic                         ready_out,
    output search_pkg::move_t            bestmove_out,
    output search_pkg::eval_t            score_out,
    output logic                         valid_out
);
    import search_pkg::*;

    localparam int DEPTH_W = $clog2(MAX_DEPTH);

    position_t          gen_position;
    move_t              gen_move;
    logic               gen_valid;
    position_t          child_position;
    move_t              parent_num_moves;
    logic               child_valid;

    position_t          eval_position;
    logic               eval_valid;
    eval_t              eval_score;
    logic               eval_done;

    logic               wr_en;
    logic [DEPTH_W-1:0] wr_depth;
    frame_t             wr_frame;
    logic [DEPTH_W-1:0] cur_depth;
    frame_t             cur_frame;
    frame_t             parent_frame;

    search_coordinator #(
        .MAX_DEPTH(MAX_DEPTH)
    ) coordinator (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .board_in(board_in),
        .board_valid_in(board_valid_in),
        .go_in(go_in),
        .time_in(time_in),
        .depth_in(depth_in),
        .cur_frame(cur_frame),
        .parent_frame(parent_frame),
        .child_position(child_position),
        .parent_num_moves(parent_num_moves),
        .child_valid(child_valid),
        .eval_score(eval_score),
        .eval_done(eval_done),
        .gen_position(gen_position),
        .gen_move(gen_move),
        .gen_valid(gen_valid),
        .eval_position(eval_position),
        .eval_valid(eval_valid),
        .wr_en(wr_en),
        .wr_depth(wr_depth),
        .wr_frame(wr_frame),
        .cur_depth(cur_depth),
        .ready_out(ready_out),
        .bestmove_out(bestmove_out),
        .score_out(score_out),
        .valid_out(valid_out)
    );

    search_stack #(
        .MAX_DEPTH(MAX_DEPTH)
    ) stack (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .cur_depth(cur_depth),
        .wr_en(wr_en),
        .wr_depth(wr_depth),
        .wr_frame(wr_frame),
        .cur_frame(cur_frame),
        .parent_frame(parent_frame)
    );

    move_generator movegen (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .gen_position(gen_position),
        .gen_move(gen_move),
        .gen_valid(gen_valid),
        .child_position(child_position),
        .parent_num_moves(parent_num_moves),
        .child_valid(child_valid)
    );

    position_evaluator poseval (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .eval_position(eval_position),
        .eval_valid(eval_valid),
        .eval_score(eval_score),
        .eval_done(eval_done)
    );

endmodule

// File: design/search_pkg.sv
package search_pkg;

    // synthetic game rules
    localparam int KEY_W = 16;
    localparam int ROT_AMOUNT = 5;
    localparam int BASE_MOVES = 2;
    localparam int EVAL_KEY_W = 11;

    localparam int MOVE_W = 3;
    localparam int EVAL_W = 16;

    typedef struct packed {
        logic [KEY_W-1:0] key;
        logic             side;
    } position_t;

    typedef logic [MOVE_W-1:0] move_t;

    typedef logic signed [EVAL_W-1:0] eval_t;

    // search window bounds
    localparam eval_t EVAL_INF = 16'sd32700;
    localparam eval_t SCORE_MIN = -16'sd32760;

    localparam logic [KEY_W-1:0] MIX_CONSTANT = 16'h2f1b;

    // one entry of the per-depth position stack
    typedef struct packed {
        position_t position;
        eval_t     alpha;
        eval_t     beta;
        eval_t     score;
        move_t     move_idx;
        move_t     num_moves;
    } frame_t;

    typedef enum logic [2:0] {
        SEARCH_READY,
        SEARCH_NEXT,
        SEARCH_GENERATING,
        SEARCH_WRITEBACK,
        SEARCH_FINISH
    } search_state_e;

endpackage

// File: design/search_stack.sv
`timescale 1ns/1ps

module search_stack #(
    parameter int MAX_DEPTH = 16
) (
    input  logic                         clk_in,
    input  logic                         rst_in,
    input  logic [$clog2(MAX_DEPTH)-1:0] cur_depth,
    input  logic                         wr_en,
    input  logic [$clog2(MAX_DEPTH)-1:0] wr_depth,
    input  search_pkg::frame_t           wr_frame,
    output search_pkg::frame_t           cur_frame,
    output search_pkg::frame_t           parent_frame
);
    import search_pkg::*;

    localparam int DEPTH_W = $clog2(MAX_DEPTH);

    frame_t             frames [MAX_DEPTH];
    logic [DEPTH_W-1:0] parent_depth;

    // the root has no parent and folds onto itself
    assign parent_depth = (cur_depth == '0) ? '0 : cur_depth - 1'b1;

    always_ff @(posedge clk_in) begin
        if (wr_en && !rst_in) begin
            frames[wr_depth] <= wr_frame;
        end
    end

    assign cur_frame = frames[cur_depth];
    assign parent_frame = frames[parent_depth];

endmodule

// File: run.sh
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module search_tb -o search_sim \
    && ./obj_dir/search_sim | grep "Testbench passed" \
    && echo "simulation result: ok" \
    || { echo "simulation result: error"; exit 1; }

// File: tb.f
design/search_pkg.sv
design/move_generator.sv
design/position_evaluator.sv
design/search_stack.sv
design/search_coordinator.sv
design/search_engine_top.sv
bench/search_assertions.sv
bench/search_tb.sv
